/* rtl/pkt_ctrl_pkg.sv */
// Shared widths, ASCII message codes, status codes and FSM states of the packet controller
package pkt_ctrl_pkg;

   //////////////////////////////////////////////////
   // Widths
   //////////////////////////////////////////////////
   localparam int WORD_NBIT     = 16;
   localparam int BYTE_NBIT     = 8;
   localparam int IO_UNIT_NBIT  = 8;
   localparam int IO_BANK_NUM   = 3;
   localparam int IO_BANK_NBIT  = 2;
   localparam int IO_DATA_NUM   = 3;
   localparam int BUF_ADDR_NBIT = 4;
   localparam int MSG_DATA_NBIT = 24;

   //////////////////////////////////////////////////
   // Message characters
   //////////////////////////////////////////////////
   localparam logic [WORD_NBIT-1:0] MSG_HEAD  = "$$";
   localparam logic [BYTE_NBIT-1:0] MSG_END_N = 8'h0A;
   localparam logic [BYTE_NBIT-1:0] MSG_END_R = 8'h0D;
   localparam logic [WORD_NBIT-1:0] MSG_PASS  = "PA";
   localparam logic [WORD_NBIT-1:0] MSG_FAIL  = "FA";

   typedef enum logic [WORD_NBIT-1:0] {
      MSG_TYPE_HANDSHAKE = "00",
      MSG_TYPE_IOCTRL    = "02"
   } msg_type_e;

   typedef enum logic [WORD_NBIT-1:0] {
      MSG_MODE_SETDATA = "01",
      MSG_MODE_EXEDATA = "02",
      MSG_MODE_SEXDATA = "03"
   } msg_mode_e;

   // Tens digit follows the mode, units digit the result
   typedef enum logic [WORD_NBIT-1:0] {
      CODE_BAD_MODE = "00",
      CODE_SET_OK   = "01",
      CODE_SET_LEN  = "02",
      CODE_SET_BAD  = "03",
      CODE_EXE_OK   = "11",
      CODE_EXE_LEN  = "12",
      CODE_EXE_BAD  = "13",
      CODE_SEX_OK   = "21",
      CODE_SEX_LEN  = "22",
      CODE_SEX_BAD  = "23"
   } status_code_e;

   //////////////////////////////////////////////////
   // FSM states
   //////////////////////////////////////////////////
   typedef enum logic [2:0] {
      RX_IDLE, RX_HEAD, RX_TYPE, RX_MODE, RX_CHADDR, RX_DATA, RX_END
   } rx_state_e;

   typedef enum logic [2:0] {
      TX_IDLE, TX_HEAD, TX_TYPE, TX_PF, TX_CODE, TX_CHADDR, TX_DATA, TX_END
   } tx_state_e;

endpackage

/* rtl/hex_codec.sv */
// ASCII hex codec, two characters to a byte with an error flag and a byte back to two characters
`timescale 1ns/1ps
module hex_codec (
   input  logic [pkt_ctrl_pkg::WORD_NBIT-1:0] i_char,
   output logic [pkt_ctrl_pkg::BYTE_NBIT-1:0] o_int,
   output logic                               o_err,
   input  logic [pkt_ctrl_pkg::BYTE_NBIT-1:0] i_int,
   output logic [pkt_ctrl_pkg::WORD_NBIT-1:0] o_char
);
   import pkt_ctrl_pkg::*;

   logic [4:0] dec_hi;
   logic [4:0] dec_lo;

   // Returns {error, nibble}, either case accepted
   function automatic logic [4:0] char_to_nib(input logic [7:0] c);
      logic [7:0] d;
      logic       bad;
      bad = 1'b0;
      if (c >= "0" && c <= "9") begin
         d = c - "0";
      end else if (c >= "a" && c <= "f") begin
         d = c - "a" + 8'd10;
      end else if (c >= "A" && c <= "F") begin
         d = c - "A" + 8'd10;
      end else begin
         d   = 8'h00;
         bad = 1'b1;
      end
      return {bad, d[3:0]};
   endfunction

   function automatic logic [7:0] nib_to_char(input logic [3:0] n);
      return (n < 4'd10) ? {4'h0, n} + "0" : {4'h0, n} + "A" - 8'd10;
   endfunction

   // More significant character sits in the low byte
   assign dec_hi = char_to_nib(i_char[BYTE_NBIT-1:0]);
   assign dec_lo = char_to_nib(i_char[WORD_NBIT-1:BYTE_NBIT]);
   assign o_int  = {dec_hi[3:0], dec_lo[3:0]};
   assign o_err  = dec_hi[4] | dec_lo[4];

   assign o_char = {nib_to_char(i_int[BYTE_NBIT/2-1:0]),
                    nib_to_char(i_int[BYTE_NBIT-1:BYTE_NBIT/2])};

endmodule

/* rtl/rx_frame_parser.sv */
// Receive FSM that pulls type, mode, channel and payload out of one host frame
`timescale 1ns/1ps
module rx_frame_parser (
   input  logic                                   clk,
   input  logic                                   i_rst_n,
   input  logic                                   i_rx_vd,
   input  logic [pkt_ctrl_pkg::WORD_NBIT-1:0]     i_rx_data,
   input  logic                                   i_rx_sop,
   input  logic                                   i_rx_eop,
   output pkt_ctrl_pkg::msg_type_e                o_msg_type,
   output pkt_ctrl_pkg::msg_mode_e                o_msg_mode,
   output logic [pkt_ctrl_pkg::BYTE_NBIT-1:0]     o_ch_addr,
   output logic [pkt_ctrl_pkg::WORD_NBIT-1:0]     o_ch_char,
   output logic [pkt_ctrl_pkg::MSG_DATA_NBIT-1:0] o_data,
   output logic [3:0]                             o_data_cnt,
   output logic                                   o_msg_err,
   output logic                                   o_msg_done
);
   import pkt_ctrl_pkg::*;

   rx_state_e            state;
   logic [BYTE_NBIT-1:0] dec_byte;
   logic                 dec_err;
   logic                 is_end;

   hex_codec u_hex (
      .i_char (i_rx_data),
      .o_int  (dec_byte),
      .o_err  (dec_err),
      .i_int  ('0),
      .o_char ()
   );

   // LF or CR in the low byte closes the frame
   assign is_end = (i_rx_data[BYTE_NBIT-1:0] == MSG_END_N) ||
                   (i_rx_data[BYTE_NBIT-1:0] == MSG_END_R);

   //////////////////////////////////////////////////
   // State walk
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state      <= RX_IDLE;
         o_msg_done <= 1'b0;
      end else begin
         o_msg_done <= 1'b0;
         case (state)
            RX_IDLE: begin
               if (i_rx_sop)
                  state <= RX_HEAD;
            end
            RX_HEAD: begin
               if (i_rx_vd && i_rx_data == MSG_HEAD)
                  state <= RX_TYPE;
            end
            RX_TYPE: begin
               if (i_rx_vd)
                  state <= RX_MODE;
            end
            RX_MODE: begin
               if (i_rx_vd)
                  state <= is_end ? RX_END : RX_CHADDR;
            end
            RX_CHADDR: begin
               if (i_rx_vd)
                  state <= is_end ? RX_END : RX_DATA;
            end
            RX_DATA: begin
               if (i_rx_vd && is_end)
                  state <= RX_END;
            end
            RX_END: ;
            default: state <= RX_IDLE;
         endcase
         // eop closes the frame from any active state
         if (i_rx_eop && state != RX_IDLE) begin
            state      <= RX_IDLE;
            o_msg_done <= 1'b1;
         end
      end
   end

   //////////////////////////////////////////////////
   // Field capture
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (state == RX_IDLE && i_rx_sop) begin
         o_msg_type <= msg_type_e'('0);
         o_msg_mode <= msg_mode_e'('0);
         o_ch_addr  <= '0;
         o_ch_char  <= '0;
         o_data     <= '0;
         o_data_cnt <= '0;
         o_msg_err  <= 1'b0;
      end else if (i_rx_vd) begin
         case (state)
            RX_TYPE: o_msg_type <= msg_type_e'(i_rx_data);
            RX_MODE: begin
               if (!is_end)
                  o_msg_mode <= msg_mode_e'(i_rx_data);
            end
            RX_CHADDR: begin
               if (!is_end) begin
                  o_ch_addr <= dec_byte;
                  o_ch_char <= i_rx_data;
                  o_msg_err <= o_msg_err | dec_err;
               end
            end
            RX_DATA: begin
               if (!is_end) begin
                  o_data    <= {o_data[MSG_DATA_NBIT-BYTE_NBIT-1:0], dec_byte};
                  o_msg_err <= o_msg_err | dec_err;
                  // Saturate so an overlong frame never aliases a valid length
                  if (o_data_cnt != 4'hF)
                     o_data_cnt <= o_data_cnt + 4'd1;
               end
            end
            default: ;
         endcase
      end
   end

   // Host must not send words between eop and the next sop
   a_no_vd_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
      state == RX_IDLE |-> !i_rx_vd)
      else $error("rx word outside a frame");

endmodule

/* rtl/cmd_exec.sv */
// Command evaluator: pass/fail status, IO strobes and reply start for a finished frame
`timescale 1ns/1ps
module cmd_exec (
   input  logic                                  clk,
   input  logic                                  i_rst_n,
   input  pkt_ctrl_pkg::msg_type_e               i_msg_type,
   input  pkt_ctrl_pkg::msg_mode_e               i_msg_mode,
   input  logic [pkt_ctrl_pkg::BYTE_NBIT-1:0]    i_ch_addr,
   input  logic [3:0]                            i_data_cnt,
   input  logic                                  i_msg_err,
   input  logic                                  i_msg_done,
   output logic                                  o_set,
   output logic                                  o_exe,
   output logic [pkt_ctrl_pkg::IO_BANK_NBIT-1:0] o_bank,
   output logic                                  o_reply_start,
   output pkt_ctrl_pkg::msg_type_e               o_reply_type,
   output logic [pkt_ctrl_pkg::WORD_NBIT-1:0]    o_pf,
   output pkt_ctrl_pkg::status_code_e            o_code
);
   import pkt_ctrl_pkg::*;

   logic         bad_data;
   logic         is_set;
   logic         is_exe;
   logic         len_ok;
   logic         pass;
   logic         known_type;
   status_code_e io_code;

   // Length error wins over bad data
   always_comb begin
      bad_data = i_msg_err || (i_ch_addr >= BYTE_NBIT'(IO_BANK_NUM));
      is_set   = 1'b0;
      is_exe   = 1'b0;
      len_ok   = 1'b0;
      case (i_msg_mode)
         MSG_MODE_SETDATA: begin
            is_set  = 1'b1;
            len_ok  = (i_data_cnt == 4'(IO_DATA_NUM));
            io_code = !len_ok ? CODE_SET_LEN : (bad_data ? CODE_SET_BAD : CODE_SET_OK);
         end
         MSG_MODE_EXEDATA: begin
            is_exe  = 1'b1;
            len_ok  = (i_data_cnt == 4'd0);
            io_code = !len_ok ? CODE_EXE_LEN : (bad_data ? CODE_EXE_BAD : CODE_EXE_OK);
         end
         MSG_MODE_SEXDATA: begin
            is_set  = 1'b1;
            is_exe  = 1'b1;
            len_ok  = (i_data_cnt == 4'(IO_DATA_NUM));
            io_code = !len_ok ? CODE_SEX_LEN : (bad_data ? CODE_SEX_BAD : CODE_SEX_OK);
         end
         default: io_code = CODE_BAD_MODE;
      endcase
      pass       = (is_set || is_exe) && len_ok && !bad_data;
      known_type = (i_msg_type == MSG_TYPE_HANDSHAKE) || (i_msg_type == MSG_TYPE_IOCTRL);
   end

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         o_set         <= 1'b0;
         o_exe         <= 1'b0;
         o_bank        <= '0;
         o_reply_start <= 1'b0;
      end else begin
         o_set         <= 1'b0;
         o_exe         <= 1'b0;
         o_reply_start <= i_msg_done && known_type;
         if (i_msg_done && i_msg_type == MSG_TYPE_IOCTRL && pass) begin
            o_set  <= is_set;
            o_exe  <= is_exe;
            o_bank <= i_ch_addr[IO_BANK_NBIT-1:0];
         end
      end
   end

   // Reply fields hold until the next known frame
   always_ff @(posedge clk) begin
      if (i_msg_done && known_type) begin
         o_reply_type <= i_msg_type;
         if (i_msg_type == MSG_TYPE_HANDSHAKE) begin
            o_pf   <= MSG_PASS;
            o_code <= CODE_SET_OK;
         end else begin
            o_pf   <= pass ? MSG_PASS : MSG_FAIL;
            o_code <= io_code;
         end
      end
   end

endmodule

/* rtl/io_bank_regs.sv */
// IO bank registers with masked set, pin drive on execute and readback of the selected bank
`timescale 1ns/1ps
module io_bank_regs #(
   parameter int IO_BANK_NUM  = 3,
   parameter int IO_UNIT_NBIT = 8
) (
   input  logic                                   clk,
   input  logic                                   i_rst_n,
   input  logic                                   i_set,
   input  logic                                   i_exe,
   input  logic [pkt_ctrl_pkg::IO_BANK_NBIT-1:0]  i_bank,
   input  logic [pkt_ctrl_pkg::MSG_DATA_NBIT-1:0] i_data,
   input  logic [IO_BANK_NUM*IO_UNIT_NBIT-1:0]    i_io_db,
   output logic [IO_BANK_NUM*IO_UNIT_NBIT-1:0]    o_io_dir,
   output logic [IO_BANK_NUM*IO_UNIT_NBIT-1:0]    o_io_db,
   output logic [IO_UNIT_NBIT-1:0]                o_cur_mask,
   output logic [IO_UNIT_NBIT-1:0]                o_cur_dir,
   output logic [IO_UNIT_NBIT-1:0]                o_cur_data
);

   logic [IO_UNIT_NBIT-1:0] mask_q  [IO_BANK_NUM];
   logic [IO_UNIT_NBIT-1:0] dir_q   [IO_BANK_NUM];
   logic [IO_UNIT_NBIT-1:0] data_q  [IO_BANK_NUM];
   logic [IO_UNIT_NBIT-1:0] pin_dir [IO_BANK_NUM];
   logic [IO_UNIT_NBIT-1:0] pin_db  [IO_BANK_NUM];
   logic [IO_UNIT_NBIT-1:0] new_mask;
   logic [IO_UNIT_NBIT-1:0] new_dir;
   logic [IO_UNIT_NBIT-1:0] new_data;
   logic [IO_UNIT_NBIT-1:0] pin_in;

   // Payload order is mask, direction, data; dir 1 is output
   assign new_mask = i_data[3*IO_UNIT_NBIT-1 -: IO_UNIT_NBIT];
   assign pin_in   = i_io_db[i_bank*IO_UNIT_NBIT +: IO_UNIT_NBIT];
   assign new_dir  = (new_mask & dir_q[i_bank]) |
                     (~new_mask & i_data[2*IO_UNIT_NBIT-1 -: IO_UNIT_NBIT]);
   // Input bits latch the pin level seen at set time
   assign new_data = (new_mask & data_q[i_bank]) |
                     (~new_mask & ((new_dir & i_data[IO_UNIT_NBIT-1:0]) | (~new_dir & pin_in)));

   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         for (int b = 0; b < IO_BANK_NUM; b++) begin
            mask_q[b]  <= '0;
            dir_q[b]   <= '0;
            data_q[b]  <= '0;
            pin_dir[b] <= '0;
            pin_db[b]  <= '0;
         end
      end else begin
         for (int b = 0; b < IO_BANK_NUM; b++) begin
            if (i_bank == b && i_set) begin
               mask_q[b] <= new_mask;
               dir_q[b]  <= new_dir;
               data_q[b] <= new_data;
            end
            // Set-and-execute drives the freshly computed values
            if (i_bank == b && i_exe) begin
               pin_dir[b] <= i_set ? new_dir : dir_q[b];
               pin_db[b]  <= i_set ? (new_data & ~new_mask) : (data_q[b] & ~mask_q[b]);
            end
         end
      end
   end

   for (genvar g = 0; g < IO_BANK_NUM; g++) begin : g_pins
      assign o_io_dir[g*IO_UNIT_NBIT +: IO_UNIT_NBIT] = pin_dir[g];
      assign o_io_db[g*IO_UNIT_NBIT +: IO_UNIT_NBIT]  = pin_db[g];
   end

   assign o_cur_mask = mask_q[i_bank];
   assign o_cur_dir  = dir_q[i_bank];
   assign o_cur_data = data_q[i_bank];

endmodule

/* rtl/reply_builder.sv */
// Transmit FSM that writes the reply frame into the host buffer image
`timescale 1ns/1ps
module reply_builder (
   input  logic                                  clk,
   input  logic                                  i_rst_n,
   input  logic                                  i_reply_start,
   input  pkt_ctrl_pkg::msg_type_e               i_reply_type,
   input  logic [pkt_ctrl_pkg::WORD_NBIT-1:0]    i_pf,
   input  pkt_ctrl_pkg::status_code_e            i_code,
   input  logic [pkt_ctrl_pkg::WORD_NBIT-1:0]    i_ch_char,
   input  logic [pkt_ctrl_pkg::IO_UNIT_NBIT-1:0] i_cur_mask,
   input  logic [pkt_ctrl_pkg::IO_UNIT_NBIT-1:0] i_cur_dir,
   input  logic [pkt_ctrl_pkg::IO_UNIT_NBIT-1:0] i_cur_data,
   output logic                                  o_tx_vd,
   output logic [pkt_ctrl_pkg::BUF_ADDR_NBIT:0]  o_tx_addr,
   output logic [pkt_ctrl_pkg::WORD_NBIT-1:0]    o_tx_data,
   output logic                                  o_tx_eop
);
   import pkt_ctrl_pkg::*;

   // Words 0..4 are head, type, pf, code and channel
   localparam logic [BUF_ADDR_NBIT-1:0] LAST_DATA_ADDR = BUF_ADDR_NBIT'(4 + IO_DATA_NUM);
   localparam logic [BUF_ADDR_NBIT-1:0] END_ADDR       = LAST_DATA_ADDR + 1'b1;

   tx_state_e                state;
   logic [BUF_ADDR_NBIT-1:0] addr;
   logic                     io_reply;
   logic [MSG_DATA_NBIT-1:0] payload;
   logic [WORD_NBIT-1:0]     enc_char;

   hex_codec u_hex (
      .i_char ('0),
      .o_int  (),
      .o_err  (),
      .i_int  (payload[MSG_DATA_NBIT-1 -: BYTE_NBIT]),
      .o_char (enc_char)
   );

   //////////////////////////////////////////////////
   // Word sequencer
   //////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (!i_rst_n) begin
         state    <= TX_IDLE;
         addr     <= '0;
         io_reply <= 1'b0;
      end else begin
         if (state == TX_IDLE)
            addr <= '0;
         else
            addr <= addr + 1'b1;
         case (state)
            TX_IDLE: begin
               if (i_reply_start) begin
                  state    <= TX_HEAD;
                  io_reply <= (i_reply_type != MSG_TYPE_HANDSHAKE);
               end
            end
            TX_HEAD:   state <= TX_TYPE;
            TX_TYPE:   state <= TX_PF;
            TX_PF:     state <= TX_CODE;
            TX_CODE:   state <= io_reply ? TX_CHADDR : TX_IDLE;
            TX_CHADDR: state <= TX_DATA;
            TX_DATA: begin
               if (addr == LAST_DATA_ADDR)
                  state <= TX_END;
            end
            TX_END: begin
               if (addr == '1)
                  state <= TX_IDLE;
            end
            default: state <= TX_IDLE;
         endcase
      end
   end

   // Bank bytes are sampled once, then shifted out MSB byte first
   always_ff @(posedge clk) begin
      if (state == TX_CHADDR)
         payload <= {i_cur_mask, i_cur_dir, i_cur_data};
      else if (state == TX_DATA)
         payload <= payload << BYTE_NBIT;
   end

   always_comb begin
      o_tx_data = '0;
      case (state)
         TX_HEAD:   o_tx_data = MSG_HEAD;
         TX_TYPE:   o_tx_data = i_reply_type;
         TX_PF:     o_tx_data = i_pf;
         TX_CODE:   o_tx_data = i_code;
         TX_CHADDR: o_tx_data = i_ch_char;
         TX_DATA:   o_tx_data = enc_char;
         TX_END: begin
            // End marker once, zero padding after it
            if (addr == END_ADDR)
               o_tx_data = {MSG_END_N, MSG_END_R};
         end
         default: ;
      endcase
   end

   assign o_tx_vd   = (state != TX_IDLE);
   assign o_tx_addr = {io_reply, addr};
   assign o_tx_eop  = (state == TX_CODE && !io_reply) || (state == TX_END && addr == '1);

   // No back-pressure, so a new frame must not finish during a reply
   a_start_idle: assert property (@(posedge clk) disable iff (!i_rst_n)
      i_reply_start |-> state == TX_IDLE)
      else $error("reply start while a reply is busy");

endmodule

/* rtl/pkt_ctrl_top.sv */
// Packet controller top: frame parser, command evaluator, IO banks and reply builder
`timescale 1ns/1ps
module pkt_ctrl_top #(
   parameter int IO_BANK_NUM  = pkt_ctrl_pkg::IO_BANK_NUM,
   parameter int IO_UNIT_NBIT = pkt_ctrl_pkg::IO_UNIT_NBIT
) (
   input  logic                                 clk,
   input  logic                                 i_rst_n,
   input  logic                                 i_rx_vd,
   input  logic [pkt_ctrl_pkg::WORD_NBIT-1:0]   i_rx_data,
   input  logic                                 i_rx_sop,
   input  logic                                 i_rx_eop,
   output logic                                 o_tx_vd,
   output logic [pkt_ctrl_pkg::BUF_ADDR_NBIT:0] o_tx_addr,
   output logic [pkt_ctrl_pkg::WORD_NBIT-1:0]   o_tx_data,
   output logic                                 o_tx_eop,
   input  logic [IO_BANK_NUM*IO_UNIT_NBIT-1:0]  i_io_db,
   output logic [IO_BANK_NUM*IO_UNIT_NBIT-1:0]  o_io_dir,
   output logic [IO_BANK_NUM*IO_UNIT_NBIT-1:0]  o_io_db
);
   import pkt_ctrl_pkg::*;

   msg_type_e                msg_type;
   msg_mode_e                msg_mode;
   logic [BYTE_NBIT-1:0]     ch_addr;
   logic [WORD_NBIT-1:0]     ch_char;
   logic [MSG_DATA_NBIT-1:0] msg_data;
   logic [3:0]               data_cnt;
   logic                     msg_err;
   logic                     msg_done;
   logic                     io_set;
   logic                     io_exe;
   logic [IO_BANK_NBIT-1:0]  io_bank;
   logic                     reply_start;
   msg_type_e                reply_type;
   logic [WORD_NBIT-1:0]     reply_pf;
   status_code_e             reply_code;
   logic [IO_UNIT_NBIT-1:0]  cur_mask;
   logic [IO_UNIT_NBIT-1:0]  cur_dir;
   logic [IO_UNIT_NBIT-1:0]  cur_data;

   rx_frame_parser u_parser (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_rx_vd    (i_rx_vd),
      .i_rx_data  (i_rx_data),
      .i_rx_sop   (i_rx_sop),
      .i_rx_eop   (i_rx_eop),
      .o_msg_type (msg_type),
      .o_msg_mode (msg_mode),
      .o_ch_addr  (ch_addr),
      .o_ch_char  (ch_char),
      .o_data     (msg_data),
      .o_data_cnt (data_cnt),
      .o_msg_err  (msg_err),
      .o_msg_done (msg_done)
   );

   cmd_exec u_exec (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_msg_type    (msg_type),
      .i_msg_mode    (msg_mode),
      .i_ch_addr     (ch_addr),
      .i_data_cnt    (data_cnt),
      .i_msg_err     (msg_err),
      .i_msg_done    (msg_done),
      .o_set         (io_set),
      .o_exe         (io_exe),
      .o_bank        (io_bank),
      .o_reply_start (reply_start),
      .o_reply_type  (reply_type),
      .o_pf          (reply_pf),
      .o_code        (reply_code)
   );

   io_bank_regs #(
      .IO_BANK_NUM  (IO_BANK_NUM),
      .IO_UNIT_NBIT (IO_UNIT_NBIT)
   ) u_io (
      .clk        (clk),
      .i_rst_n    (i_rst_n),
      .i_set      (io_set),
      .i_exe      (io_exe),
      .i_bank     (io_bank),
      .i_data     (msg_data),
      .i_io_db    (i_io_db),
      .o_io_dir   (o_io_dir),
      .o_io_db    (o_io_db),
      .o_cur_mask (cur_mask),
      .o_cur_dir  (cur_dir),
      .o_cur_data (cur_data)
   );

   reply_builder u_reply (
      .clk           (clk),
      .i_rst_n       (i_rst_n),
      .i_reply_start (reply_start),
      .i_reply_type  (reply_type),
      .i_pf          (reply_pf),
      .i_code        (reply_code),
      .i_ch_char     (ch_char),
      .i_cur_mask    (cur_mask),
      .i_cur_dir     (cur_dir),
      .i_cur_data    (cur_data),
      .o_tx_vd       (o_tx_vd),
      .o_tx_addr     (o_tx_addr),
      .o_tx_data     (o_tx_data),
      .o_tx_eop      (o_tx_eop)
   );

endmodule

/* testbench/tb_pkt_ctrl.sv */
// Table-driven testbench for the packet controller, checks reply buffer words and IO pins
`timescale 1ns/1ps
module tb_pkt_ctrl;

   localparam int NUM_TESTS   = 12;
   localparam int MAX_WORDS   = 8;
   localparam int MAX_GAP     = 3;
   // Reset, then per test a frame with gaps, the reply latency, 16 reply words and idle time
   localparam int CYCLE_LIMIT = 8 + NUM_TESTS * (3 + MAX_WORDS * (MAX_GAP + 1) + 3 + 16 + 4);

   logic        clk;
   logic        rst_n;
   logic        rx_vd;
   logic [15:0] rx_data;
   logic        rx_sop;
   logic        rx_eop;
   logic        tx_vd;
   logic [4:0]  tx_addr;
   logic [15:0] tx_data;
   logic        tx_eop;
   logic [23:0] io_db_in;
   logic [23:0] io_dir;
   logic [23:0] io_db_out;

   // Frame table
   string       t_name  [NUM_TESTS];
   logic [15:0] t_type  [NUM_TESTS];
   logic [15:0] t_mode  [NUM_TESTS];
   logic [7:0]  t_ch    [NUM_TESTS];
   int          t_ndata [NUM_TESTS];
   logic [7:0]  t_mask  [NUM_TESTS];
   logic [7:0]  t_dir   [NUM_TESTS];
   logic [7:0]  t_val   [NUM_TESTS];
   logic        t_bad   [NUM_TESTS];
   logic [15:0] t_pf    [NUM_TESTS];
   logic [15:0] t_code  [NUM_TESTS];
   int          n_loaded;

   // Expected bank registers and pins
   logic [7:0]  m_mask [3];
   logic [7:0]  m_dir  [3];
   logic [7:0]  m_data [3];
   logic [7:0]  m_pdir [3];
   logic [7:0]  m_pdb  [3];
   int          m_bank;

   logic [15:0] got_word [16];
   logic        got_hi   [16];
   int          n_words;
   logic [4:0]  eop_addr;
   logic        reply_done;

   logic [31:0] lcg_state;
   int          errors;
   int          cycles;

   pkt_ctrl_top dut0 (
      .clk       (clk),
      .i_rst_n   (rst_n),
      .i_rx_vd   (rx_vd),
      .i_rx_data (rx_data),
      .i_rx_sop  (rx_sop),
      .i_rx_eop  (rx_eop),
      .o_tx_vd   (tx_vd),
      .o_tx_addr (tx_addr),
      .o_tx_data (tx_data),
      .o_tx_eop  (tx_eop),
      .i_io_db   (io_db_in),
      .o_io_dir  (io_dir),
      .o_io_db   (io_db_out)
   );

   initial clk = 1'b0;
   always #50 clk = ~clk;

   //////////////////////////////////////////////////
   // Helpers
   //////////////////////////////////////////////////
   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   // Upper nibble character goes in the low byte
   function automatic logic [15:0] hex_word(input logic [7:0] b);
      string digits;
      digits = "0123456789ABCDEF";
      return {digits[b[3:0]], digits[b[7:4]]};
   endfunction

   task automatic add_frame(input string name, input logic [15:0] typ, input logic [15:0] mode,
                            input logic [7:0] ch, input int ndata, input logic [7:0] mask,
                            input logic [7:0] dir, input logic [7:0] val, input logic bad,
                            input logic [15:0] pf, input logic [15:0] code);
      t_name[n_loaded]  = name;
      t_type[n_loaded]  = typ;
      t_mode[n_loaded]  = mode;
      t_ch[n_loaded]    = ch;
      t_ndata[n_loaded] = ndata;
      t_mask[n_loaded]  = mask;
      t_dir[n_loaded]   = dir;
      t_val[n_loaded]   = val;
      t_bad[n_loaded]   = bad;
      t_pf[n_loaded]    = pf;
      t_code[n_loaded]  = code;
      n_loaded = n_loaded + 1;
   endtask

   task automatic load_table();
      //         name         type  mode  ch     n  mask   dir    data   bad   pf    code
      add_frame("handshake", "00", "00", 8'h00, 0, 8'h00, 8'h00, 8'h00, 1'b0, "PA", "01");
      add_frame("set b1",    "02", "01", 8'h01, 3, 8'h00, 8'hF0, 8'hA5, 1'b0, "PA", "01");
      add_frame("exe b1",    "02", "02", 8'h01, 0, 8'h00, 8'h00, 8'h00, 1'b0, "PA", "11");
      add_frame("sex b2",    "02", "03", 8'h02, 3, 8'h00, 8'hFF, 8'h3C, 1'b0, "PA", "21");
      add_frame("sex b2 msk", "02", "03", 8'h02, 3, 8'h0F, 8'h00, 8'hFF, 1'b0, "PA", "21");
      add_frame("bad char",  "02", "01", 8'h00, 3, 8'h00, 8'hFF, 8'h55, 1'b1, "FA", "03");
      add_frame("channel 3", "02", "01", 8'h03, 3, 8'h00, 8'hFF, 8'h55, 1'b0, "FA", "03");
      add_frame("set short", "02", "01", 8'h01, 2, 8'h00, 8'h0F, 8'h00, 1'b0, "FA", "02");
      add_frame("exe data",  "02", "02", 8'h01, 1, 8'hFF, 8'h00, 8'h00, 1'b0, "FA", "12");
      add_frame("bad mode",  "02", "05", 8'h01, 3, 8'h00, 8'hFF, 8'hFF, 1'b0, "FA", "00");
      add_frame("exe b2",    "02", "02", 8'h02, 0, 8'h00, 8'h00, 8'h00, 1'b0, "PA", "11");
      add_frame("handshake", "00", "00", 8'h00, 0, 8'h00, 8'h00, 8'h00, 1'b0, "PA", "01");
   endtask

   // Random idle gap, then one valid word
   task automatic put_word(input logic [15:0] w);
      logic [31:0] r;
      r = lcg_next();
      rx_vd <= 1'b0;
      repeat (r[30:29]) @(posedge clk);
      rx_vd   <= 1'b1;
      rx_data <= w;
      @(posedge clk);
   endtask

   task automatic send_frame(input int i);
      logic [15:0] w;
      logic [7:0]  bytes [3];
      bytes[0] = t_mask[i];
      bytes[1] = t_dir[i];
      bytes[2] = t_val[i];
      @(posedge clk);
      rx_sop <= 1'b1;
      @(posedge clk);
      rx_sop <= 1'b0;
      put_word("$$");
      put_word(t_type[i]);
      // Handshake frames end right after the type
      if (t_type[i] != "00") begin
         put_word(t_mode[i]);
         put_word(hex_word(t_ch[i]));
         for (int k = 0; k < t_ndata[i]; k++) begin
            w = hex_word(bytes[k]);
            if (t_bad[i] && k == 0)
               w[7:0] = "G";
            put_word(w);
         end
      end
      put_word(16'h0D0A);
      rx_vd  <= 1'b0;
      rx_eop <= 1'b1;
      @(posedge clk);
      rx_eop <= 1'b0;
   endtask

   // Masked bits keep their state, input bits take the pin level
   task automatic update_model(input int i);
      int b;
      b = int'(t_ch[i]);
      if (t_mode[i] != "02") begin
         for (int k = 0; k < 8; k++) begin
            if (!t_mask[i][k]) begin
               m_dir[b][k]  = t_dir[i][k];
               m_data[b][k] = t_dir[i][k] ? t_val[i][k] : io_db_in[b*8+k];
            end
         end
         m_mask[b] = t_mask[i];
      end
      if (t_mode[i] != "01") begin
         m_pdir[b] = m_dir[b];
         m_pdb[b]  = m_data[b] & ~m_mask[b];
      end
      m_bank = b;
   endtask

   task automatic expect_eq(input logic [31:0] got, input logic [31:0] exp, input string what);
      assert (got === exp)
      else begin
         $display("** Error: [%0t] %s: got %h, expected %h", $time, what, got, exp);
         errors = errors + 1;
      end
   endtask

   task automatic check_reply(input int i);
      logic        hs;
      int          len;
      logic [15:0] exp;
      hs  = (t_type[i] == "00");
      len = hs ? 4 : 16;
      expect_eq(n_words, len, "reply word count");
      expect_eq(eop_addr, hs ? 5'h03 : 5'h1F, "eop address");
      for (int a = 0; a < len; a++) begin
         case (a)
            0: exp = "$$";
            1: exp = t_type[i];
            2: exp = t_pf[i];
            3: exp = t_code[i];
            4: exp = hex_word(t_ch[i]);
            5: exp = hex_word(m_mask[m_bank]);
            6: exp = hex_word(m_dir[m_bank]);
            7: exp = hex_word(m_data[m_bank]);
            8: exp = 16'h0A0D;
            default: exp = 16'h0000;
         endcase
         expect_eq(got_word[a], exp, $sformatf("reply word %0d", a));
         expect_eq(got_hi[a], !hs, $sformatf("address high bit of word %0d", a));
      end
      for (int b = 0; b < 3; b++) begin
         expect_eq(io_dir[b*8 +: 8], m_pdir[b], $sformatf("o_io_dir bank %0d", b));
         expect_eq(io_db_out[b*8 +: 8], m_pdb[b], $sformatf("o_io_db bank %0d", b));
      end
   endtask

   //////////////////////////////////////////////////
   // Reply collector and watchdog
   //////////////////////////////////////////////////
   always @(negedge clk) begin
      if (tx_vd) begin
         got_word[tx_addr[3:0]] = tx_data;
         got_hi[tx_addr[3:0]]   = tx_addr[4];
         n_words = n_words + 1;
         if (tx_eop) begin
            eop_addr   = tx_addr;
            reply_done = 1'b1;
         end
      end
   end

   initial begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT) begin
         @(posedge clk);
         cycles = cycles + 1;
      end
      $display("Run timed out after %0d cycles before the test table finished", cycles);
      $display("STATUS: FAIL");
      $finish;
   end

   //////////////////////////////////////////////////
   // Main sequence
   //////////////////////////////////////////////////
   initial begin
      int          errors_before;
      int          failed_tests;
      logic [31:0] r;
      rst_n      = 1'b0;
      rx_vd      = 1'b0;
      rx_data    = '0;
      rx_sop     = 1'b0;
      rx_eop     = 1'b0;
      io_db_in   = '0;
      lcg_state  = 32'h3717_5e4d;
      errors     = 0;
      failed_tests = 0;
      n_loaded   = 0;
      n_words    = 0;
      eop_addr   = '0;
      reply_done = 1'b0;
      m_bank     = 0;
      for (int b = 0; b < 3; b++) begin
         m_mask[b] = '0;
         m_dir[b]  = '0;
         m_data[b] = '0;
         m_pdir[b] = '0;
         m_pdb[b]  = '0;
      end
      load_table();
      repeat (4) @(posedge clk);
      rst_n <= 1'b1;
      repeat (2) @(posedge clk);
      for (int i = 0; i < NUM_TESTS; i++) begin
         errors_before = errors;
         r = lcg_next();
         io_db_in <= r[23:0];
         n_words    = 0;
         reply_done = 1'b0;
         for (int a = 0; a < 16; a++) begin
            got_word[a] = 'x;
            got_hi[a]   = 1'bx;
         end
         send_frame(i);
         while (!reply_done)
            @(posedge clk);
         repeat (2) @(posedge clk);
         if (t_type[i] == "02" && t_pf[i] == "PA")
            update_model(i);
         check_reply(i);
         if (errors == errors_before) begin
            $display("Test %0d %s: ok", i, t_name[i]);
         end else begin
            $display("Test %0d %s: FAILED", i, t_name[i]);
            failed_tests = failed_tests + 1;
         end
      end
      $display("%0d tests, %0d passed, %0d failed, %0d check errors",
               NUM_TESTS, NUM_TESTS - failed_tests, failed_tests, errors);
      if (errors == 0)
         $display("STATUS: PASS");
      else
         $display("STATUS: FAIL");
      $finish;
   end

endmodule

/* pkt_ctrl.f */
rtl/pkt_ctrl_pkg.sv
rtl/hex_codec.sv
rtl/rx_frame_parser.sv
rtl/cmd_exec.sv
rtl/io_bank_regs.sv
rtl/reply_builder.sv
rtl/pkt_ctrl_top.sv
testbench/tb_pkt_ctrl.sv

/* Bender.yml */
package:
  name: pkt_ctrl

sources:
  - rtl/pkt_ctrl_pkg.sv
  - rtl/hex_codec.sv
  - rtl/rx_frame_parser.sv
  - rtl/cmd_exec.sv
  - rtl/io_bank_regs.sv
  - rtl/reply_builder.sv
  - rtl/pkt_ctrl_top.sv
  - target: simulation
    files:
      - testbench/tb_pkt_ctrl.sv
